/* logic/axil_rd_pkg.sv */
////////////////////////////////////////////////////////////
// Bus-side sizes and AXI-lite read channel bundles
// Referenced by scoped name from the fetch modules
////////////////////////////////////////////////////////////

package axil_rd_pkg;

	// Byte address width of the code bus
	localparam int addr_w = 32;

	// Read data width, two instructions per beat
	localparam int bus_w = 64;

	// Byte offset bits inside one beat
	localparam int bus_lsb = 3;

	// Read address request, ARPROT is fixed and not carried
	typedef struct packed {
		logic              valid;
		logic [addr_w-1:0] addr;
	} axil_ar_t;

	// Read response
	// Only RRESP[1] matters, it flags SLVERR or DECERR
	typedef struct packed {
		logic             valid;
		logic [bus_w-1:0] data;
		logic             err;
	} axil_r_t;

endpackage

/* logic/fetch_pkg.sv */
////////////////////////////////////////////////////////////
// CPU-side sizes, fetch limits and instruction bundles
////////////////////////////////////////////////////////////

package fetch_pkg;

	// One instruction word
	localparam int insn_w = 32;

	// Slots per bus beat
	localparam int insns_per_beat = axil_rd_pkg::bus_w / insn_w;

	// Beats requested or buffered at once
	localparam int fetch_limit = 16;

	// FIFO depth is 1 << fifo_lg
	localparam int fifo_lg = 4;

	// Outstanding and flush counters, log2(fetch_limit)+4 plus one
	localparam int count_w = 9;

	// A beat seen whole on the bus, or as its instruction slots
	typedef union packed {
		logic [axil_rd_pkg::bus_w-1:0]           word;
		logic [insns_per_beat-1:0][insn_w-1:0]   insn;
	} beat_t;

	// Buffered beat with its bus error
	typedef struct packed {
		logic  err;
		beat_t beat;
	} fifo_entry_t;

	// Instruction handed to the CPU
	typedef struct packed {
		logic                           valid;
		logic                           illegal;
		logic [axil_rd_pkg::addr_w-1:0] pc;
		logic [insn_w-1:0]              insn;
	} insn_out_t;

endpackage

/* logic/fetch_ctrl.sv */
////////////////////////////////////////////////////////////
// Fetch control: read accounting, flush of stale responses
// and request throttling for the AXI-lite prefetch
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetch_ctrl (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_new_pc,
	input  logic i_clear_cache,
	input  logic i_ar_valid,
	input  logic i_arready,
	input  logic i_rvalid,
	input  logic i_pop,
	input  logic i_out_busy,
	output logic o_restart,
	output logic o_ar_valid,
	output logic o_ar_open,
	output logic o_fifo_wr
);

	logic [fetch_pkg::count_w-1:0] outstanding;
	logic [fetch_pkg::count_w-1:0] next_outstanding;
	logic [fetch_pkg::count_w-1:0] new_flushcount;
	logic [fetch_pkg::count_w-1:0] flushcount;
	logic [fetch_pkg::count_w-1:0] fill_sum;
	logic [fetch_pkg::count_w-2:0] fill;
	logic                          full_bus;
	logic                          flushing;
	logic                          flush_request;

	// Any of these throws away everything in flight
	assign o_restart = fifo_reset || i_new_pc || i_clear_cache;

	// Address slot free or draining this cycle
	assign o_ar_open = !i_ar_valid || i_arready;

	// RREADY is tied high, so every RVALID is a beat
	assign o_fifo_wr = i_rvalid && !flushing;

	////////////////////////////////////////////////////////////
	// Outstanding reads
	////////////////////////////////////////////////////////////

	always_comb
	begin
		next_outstanding = outstanding;
		if (i_ar_valid && i_arready && !i_rvalid)
			next_outstanding = outstanding + 1'b1;
		else if (i_rvalid && !(i_ar_valid && i_arready))
			next_outstanding = outstanding - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			full_bus <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			// Keep one count of headroom for the top bit
			full_bus <= (next_outstanding >= (1 << (fetch_pkg::count_w - 1)) - 1);
		end
	end

	// Beats requested for the current stream, not yet popped
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_restart)
			fill <= '0;
		else if ((i_ar_valid && i_arready && !flush_request) && !i_pop)
			fill <= fill + 1'b1;
		else if (i_pop && !(i_ar_valid && i_arready && !flush_request))
			fill <= fill - 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Flush of responses still owed at restart
	////////////////////////////////////////////////////////////

	// Pending request counts too, it is answered later
	always_comb
	begin
		new_flushcount = outstanding;
		if (i_ar_valid)
			new_flushcount = new_flushcount + 1'b1;
		if (i_rvalid)
			new_flushcount = new_flushcount - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			flushcount <= '0;
			flushing <= 1'b0;
			flush_request <= 1'b0;
		end
		else if (o_restart)
		begin
			flushcount <= new_flushcount;
			flushing <= (new_flushcount != '0);
			// Stalled old request, still owed to the bus
			flush_request <= i_ar_valid && !i_arready;
		end
		else
		begin
			if (i_rvalid && flushcount != '0)
			begin
				flushcount <= flushcount - 1'b1;
				flushing <= (flushcount > 1);
			end
			if (i_arready)
				flush_request <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Request throttle
	////////////////////////////////////////////////////////////

	// Beats already claimed against the limit
	always_comb
	begin
		fill_sum = {1'b0, fill};
		if (i_ar_valid)
			fill_sum = fill_sum + 1'b1;
		if (i_out_busy)
			fill_sum = fill_sum + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_ar_valid <= 1'b0;
		else if (o_ar_open)
			o_ar_valid <= !(o_restart || full_bus
				|| fill_sum >= fetch_pkg::fetch_limit);
	end

endmodule

/* logic/fetch_addr_gen.sv */
////////////////////////////////////////////////////////////
// Read address generator, loads new PCs and steps by beat
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetch_addr_gen (
	input  logic                           S_AXI_ACLK,
	input  logic                           fifo_reset,
	input  logic                           i_clear_cache,
	input  logic                           i_new_pc,
	input  logic [axil_rd_pkg::addr_w-1:0] i_pc,
	input  logic                           i_ar_open,
	input  logic                           i_ar_valid,
	output logic [axil_rd_pkg::addr_w-1:0] o_araddr
);

	logic                           pending_new_pc;
	logic [axil_rd_pkg::addr_w-1:0] pending_pc;

	// New PC arrived while the address was held by the bus
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear_cache)
			pending_new_pc <= 1'b0;
		else if (i_ar_open)
			pending_new_pc <= 1'b0;
		else if (i_new_pc)
			pending_new_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// Address only moves when the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_araddr <= '0;
		else if (i_ar_open)
		begin
			if (i_new_pc)
				o_araddr <= i_pc;
			else if (pending_new_pc)
				o_araddr <= pending_pc;
			else if (i_ar_valid)
			begin
				// Next beat, slot bits dropped
				o_araddr[axil_rd_pkg::addr_w-1:axil_rd_pkg::bus_lsb]
					<= o_araddr[axil_rd_pkg::addr_w-1:axil_rd_pkg::bus_lsb] + 1'b1;
				o_araddr[axil_rd_pkg::bus_lsb-1:0] <= '0;
			end
		end
	end

endmodule

/* logic/beat_fifo.sv */
////////////////////////////////////////////////////////////
// Beat buffer between the read channel and the unpacker,
// byte order of each word is reversed on the way in
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module beat_fifo (
	input  logic                   S_AXI_ACLK,
	input  logic                   i_restart,
	input  logic                   i_wr,
	input  axil_rd_pkg::axil_r_t   i_r,
	input  logic                   i_rd,
	output fetch_pkg::fifo_entry_t o_head,
	output logic                   o_empty
);

	fetch_pkg::fifo_entry_t      mem [0:(1 << fetch_pkg::fifo_lg)-1];
	logic [fetch_pkg::fifo_lg:0] wr_ptr;
	logic [fetch_pkg::fifo_lg:0] rd_ptr;
	fetch_pkg::beat_t            raw;
	fetch_pkg::beat_t            swapped;

	// Bus word in, per-slot view for the swap
	assign raw.word = i_r.data;

	// Big-endian code image, byte 0 lands on the top byte
	always_comb
	begin
		for (int w = 0; w < fetch_pkg::insns_per_beat; w++)
		begin
			for (int b = 0; b < 4; b++)
				swapped.insn[w][(3-b)*8 +: 8] = raw.insn[w][b*8 +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			rd_ptr <= '0;
		else if (i_rd && !o_empty)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Storage, the throttle keeps it from overflowing
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[fetch_pkg::fifo_lg-1:0]] <= {i_r.err, swapped};
	end

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_head = mem[rd_ptr[fetch_pkg::fifo_lg-1:0]];

endmodule

/* logic/insn_unpack.sv */
////////////////////////////////////////////////////////////
// Splits buffered beats into single instructions for the
// CPU, with output PC and bus error tracking
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module insn_unpack (
	input  logic                           S_AXI_ACLK,
	input  logic                           i_restart,
	input  logic                           i_new_pc,
	input  logic [axil_rd_pkg::addr_w-1:0] i_pc,
	input  logic                           i_ready,
	input  fetch_pkg::fifo_entry_t         i_head,
	input  logic                           i_empty,
	output logic                           o_rd,
	output logic                           o_pop,
	output logic                           o_out_busy,
	output fetch_pkg::insn_out_t           o_insn
);

	fetch_pkg::beat_t                          out_data;
	logic [$clog2(fetch_pkg::insns_per_beat):0] out_fill;
	logic [axil_rd_pkg::bus_lsb-3:0]           shift;
	logic [axil_rd_pkg::addr_w-1:0]            pc;
	logic                                      illegal;
	logic                                      valid;

	// Instructions left in the output beat
	assign valid = (out_fill != '0);

	// Skip the lower slot only for a fresh start
	assign shift = valid ? '0 : pc[axil_rd_pkg::bus_lsb-1:2];

	// Load when empty or the last slot is leaving
	assign o_rd = !valid || (i_ready && out_fill <= 1);
	assign o_pop = o_rd && !i_empty;
	assign o_out_busy = valid && (!i_ready || out_fill > 1);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			out_fill <= '0;
		else if (o_rd)
		begin
			if (i_empty)
				out_fill <= '0;
			else if (shift != '0)
				out_fill <= 2'd1;
			else
				out_fill <= 2'd2;
		end
		else if (i_ready && valid)
			out_fill <= out_fill - 1'b1;
	end

	// Slot 0 is always the one presented
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
		begin
			if (shift != '0)
				out_data.insn[0] <= i_head.beat.insn[1];
			else
				out_data <= i_head.beat;
		end
		else if (i_ready)
			out_data.insn[0] <= out_data.insn[1];
	end

	////////////////////////////////////////////////////////////
	// PC and error
	////////////////////////////////////////////////////////////

	// Frozen once illegal, until the CPU restarts us
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pc <= i_pc;
		else if (valid && i_ready && !illegal)
		begin
			pc[axil_rd_pkg::addr_w-1:2] <= pc[axil_rd_pkg::addr_w-1:2] + 1'b1;
			pc[1:0] <= '0;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			illegal <= 1'b0;
		else if (!illegal && o_pop)
			illegal <= i_head.err;
	end

	assign o_insn.valid = valid;
	assign o_insn.illegal = illegal;
	assign o_insn.pc = pc;
	assign o_insn.insn = out_data.insn[0];

endmodule

/* logic/axil_fetch_top.sv */
////////////////////////////////////////////////////////////
// AXI-lite instruction prefetch, bus read port on one side
// and a valid/ready instruction port toward the CPU
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module axil_fetch_top (
	input  logic                           S_AXI_ACLK,
	input  logic                           fifo_reset,
	input  logic                           i_new_pc,
	input  logic [axil_rd_pkg::addr_w-1:0] i_pc,
	input  logic                           i_clear_cache,
	input  logic                           i_ready,
	input  logic                           i_arready,
	input  axil_rd_pkg::axil_r_t           i_r,
	output axil_rd_pkg::axil_ar_t          o_ar,
	output fetch_pkg::insn_out_t           o_insn
);

	logic                           restart;
	logic                           ar_valid;
	logic                           ar_open;
	logic [axil_rd_pkg::addr_w-1:0] araddr;
	logic                           fifo_wr;
	logic                           fifo_rd;
	logic                           fifo_empty;
	fetch_pkg::fifo_entry_t         head;
	logic                           pop;
	logic                           out_busy;

	// Read address channel
	assign o_ar.valid = ar_valid;
	assign o_ar.addr = araddr;

	// Accounting, flush and throttle
	fetch_ctrl ctrl_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_ar_valid    (ar_valid),
		.i_arready     (i_arready),
		.i_rvalid      (i_r.valid),
		.i_pop         (pop),
		.i_out_busy    (out_busy),
		.o_restart     (restart),
		.o_ar_valid    (ar_valid),
		.o_ar_open     (ar_open),
		.o_fifo_wr     (fifo_wr)
	);

	fetch_addr_gen addr_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_clear_cache (i_clear_cache),
		.i_new_pc      (i_new_pc),
		.i_pc          (i_pc),
		.i_ar_open     (ar_open),
		.i_ar_valid    (ar_valid),
		.o_araddr      (araddr)
	);

	// Returned beats, swapped
	beat_fifo fifo_i (
		.S_AXI_ACLK (S_AXI_ACLK),
		.i_restart  (restart),
		.i_wr       (fifo_wr),
		.i_r        (i_r),
		.i_rd       (fifo_rd),
		.o_head     (head),
		.o_empty    (fifo_empty)
	);

	insn_unpack unpack_i (
		.S_AXI_ACLK (S_AXI_ACLK),
		.i_restart  (restart),
		.i_new_pc   (i_new_pc),
		.i_pc       (i_pc),
		.i_ready    (i_ready),
		.i_head     (head),
		.i_empty    (fifo_empty),
		.o_rd       (fifo_rd),
		.o_pop      (pop),
		.o_out_busy (out_busy),
		.o_insn     (o_insn)
	);

endmodule

/* test/axil_code_mem.sv */
////////////////////////////////////////////////////////////
// AXI-lite code memory model for the fetch testbench, with
// random ARREADY stalls, response latency and an error region
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module axil_code_mem (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	input  axil_rd_pkg::axil_ar_t i_ar,
	output logic                  o_arready,
	output axil_rd_pkg::axil_r_t  o_r
);

	// Reads here answer with the error bit
	localparam logic [31:0] err_base = 32'h0000_8000;

	logic                 arready = 1'b0;
	axil_rd_pkg::axil_r_t resp = '0;
	logic [31:0]          rng = 32'h616b56c8;
	int                   cycle = 0;
	logic [31:0]          addr_q [$];
	int                   due_q [$];

	assign o_arready = arready;
	assign o_r = resp;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Code pattern, one word per address
	function automatic logic [31:0] code_word(input logic [31:0] a);
		return a ^ 32'hc0de0000;
	endfunction

	function automatic logic [31:0] byte_reverse(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	always @(posedge S_AXI_ACLK)
	begin
		logic [31:0] base;
		if (fifo_reset)
		begin
			cycle = 0;
			addr_q.delete();
			due_q.delete();
			arready <= 1'b0;
			resp <= '0;
		end
		else
		begin
			cycle = cycle + 1;
			// Accepted address, answered 0 to 3 cycles later
			if (i_ar.valid && arready)
			begin
				rng = xorshift32(rng);
				addr_q.push_back(i_ar.addr);
				due_q.push_back(cycle + int'(rng[1:0]));
			end
			// In order, one beat per cycle, RREADY is always high
			if (addr_q.size() != 0 && due_q[0] <= cycle)
			begin
				base = addr_q.pop_front() & ~32'h7;
				void'(due_q.pop_front());
				resp.valid <= 1'b1;
				resp.err <= (base >= err_base);
				if (base >= err_base)
					resp.data <= '0;
				else
					resp.data <= {byte_reverse(code_word(base + 32'd4)),
						byte_reverse(code_word(base))};
			end
			else
				resp <= '0;
			// Stall about one cycle in eight
			rng = xorshift32(rng);
			arready <= (rng[2:0] != 3'b000);
		end
	end

endmodule

/* test/fetch_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the AXI-lite prefetch that runs fetch streams
// against the code memory model and checks each instruction
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module fetch_tb;

	localparam logic [31:0] err_base = 32'h0000_8000;

	// One fetch stream with an optional restart in the middle
	typedef struct packed {
		logic [31:0] start_pc;
		int          n_insn;
		logic        rand_ready;
		int          inj_cycle;
		logic        inj_clear;
		logic [31:0] inj_pc;
		logic [31:0] last_pc;
	} row_t;

	localparam int n_rows = 8;

	// start, count, ready drops, inject cycle, clear, inject pc, last pc
	localparam row_t rows [n_rows] = '{
		'{32'h0000_0100, 20, 1'b0, 0, 1'b0, 32'h0000_0000, 32'h0000_014c},
		'{32'h0000_0204,  9, 1'b1, 0, 1'b0, 32'h0000_0000, 32'h0000_0224},
		'{32'h0000_0400, 12, 1'b0, 5, 1'b0, 32'h0000_1004, 32'h0000_1030},
		'{32'h0000_0600, 10, 1'b1, 8, 1'b1, 32'h0000_2000, 32'h0000_2024},
		'{32'h0000_3000, 40, 1'b1, 0, 1'b0, 32'h0000_0000, 32'h0000_309c},
		'{32'h0000_7004, 10, 1'b1, 9, 1'b0, 32'h0000_0500, 32'h0000_0524},
		'{32'h0000_7fe8, 12, 1'b1, 0, 1'b0, 32'h0000_0000, 32'h0000_8000},
		'{32'h0000_0040,  6, 1'b0, 0, 1'b0, 32'h0000_0000, 32'h0000_0054}
	};

	logic                  S_AXI_ACLK = 1'b0;
	logic                  fifo_reset = 1'b1;
	logic                  i_new_pc = 1'b0;
	logic [31:0]           i_pc = '0;
	logic                  i_clear_cache = 1'b0;
	logic                  i_ready = 1'b0;
	logic                  arready;
	axil_rd_pkg::axil_r_t  r;
	axil_rd_pkg::axil_ar_t ar;
	fetch_pkg::insn_out_t  insn;
	logic [31:0]           rng = 32'h616b56c8;
	int                    checks = 0;
	int                    insn_errs = 0;
	int                    bit_errs = 0;
	int                    cycles = 0;
	int                    limit;

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	axil_fetch_top dut_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_pc          (i_pc),
		.i_clear_cache (i_clear_cache),
		.i_ready       (i_ready),
		.i_arready     (arready),
		.i_r           (r),
		.o_ar          (ar),
		.o_insn        (insn)
	);

	axil_code_mem mem_i (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_ar       (ar),
		.o_arready  (arready),
		.o_r        (r)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected output at a pc with zero data past the error base
	function automatic fetch_pkg::insn_out_t expected_insn(input logic [31:0] pc);
		fetch_pkg::insn_out_t e;
		e.valid = 1'b1;
		e.illegal = (pc >= err_base);
		e.pc = pc;
		e.insn = e.illegal ? 32'h0 : (pc ^ 32'hc0de0000);
		return e;
	endfunction

	function automatic int timeout_limit();
		int total;
		total = 200;
		for (int i = 0; i < n_rows; i++)
			total += 40 * rows[i].n_insn;
		return total;
	endfunction

	task automatic check_insn(input string what, input fetch_pkg::insn_out_t exp,
		input fetch_pkg::insn_out_t got);
		checks++;
		if (got !== exp)
		begin
			insn_errs++;
			$display("[ERROR] %0t ns: %s, expected v%0b i%0b pc %h insn %h", $time, what,
				exp.valid, exp.illegal, exp.pc, exp.insn);
			$display("        got v%0b i%0b pc %h insn %h", got.valid, got.illegal,
				got.pc, got.insn);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic got);
		checks++;
		if (got !== exp)
		begin
			bit_errs++;
			$display("[ERROR] %0t ns: %s, expected %0b got %0b", $time, what, exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stream control
	////////////////////////////////////////////////////////////

	// Optional cache clear and a new pc that must empty the output
	task automatic restart_stream(input logic clear_first, input logic [31:0] pc);
		if (clear_first)
		begin
			@(posedge S_AXI_ACLK);
			i_ready <= 1'b0;
			i_clear_cache <= 1'b1;
			@(posedge S_AXI_ACLK);
			i_clear_cache <= 1'b0;
			@(negedge S_AXI_ACLK);
			check_bit("valid after cache clear", 1'b0, insn.valid);
		end
		@(posedge S_AXI_ACLK);
		i_ready <= 1'b0;
		i_new_pc <= 1'b1;
		i_pc <= pc;
		@(posedge S_AXI_ACLK);
		i_new_pc <= 1'b0;
		@(negedge S_AXI_ACLK);
		check_bit("valid after new pc", 1'b0, insn.valid);
	endtask

	// Sample on the falling edge and drive on the rising edge
	task automatic run_row(input row_t row);
		logic [31:0]          cur;
		fetch_pkg::insn_out_t held;
		fetch_pkg::insn_out_t last;
		logic                 hold;
		logic                 next_ready;
		int                   accepted;
		int                   cyc;
		cur = row.start_pc;
		restart_stream(1'b0, row.start_pc);
		hold = 1'b0;
		accepted = 0;
		cyc = 0;
		while (accepted < row.n_insn)
		begin
			@(negedge S_AXI_ACLK);
			cyc++;
			if (hold)
				check_insn("output held under back-pressure", held, insn);
			// Taken on the coming rising edge
			if (insn.valid && i_ready)
			begin
				check_insn("accepted instruction", expected_insn(cur), insn);
				last = insn;
				accepted++;
				// PC freezes on the first error address
				if (cur < err_base)
					cur = cur + 32'd4;
			end
			hold = insn.valid && !i_ready;
			held = insn;
			rng = xorshift32(rng);
			next_ready = !row.rand_ready || (rng[1:0] != 2'b00);
			if (row.inj_cycle != 0 && cyc == row.inj_cycle)
			begin
				restart_stream(row.inj_clear, row.inj_pc);
				cur = row.inj_pc;
				accepted = 0;
				hold = 1'b0;
			end
			else
			begin
				@(posedge S_AXI_ACLK);
				i_ready <= next_ready;
			end
		end
		check_insn("last instruction of row", expected_insn(row.last_pc), last);
	endtask

	// Watchdog
	always @(posedge S_AXI_ACLK)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("Timeout: fetch streams did not finish within %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		limit = timeout_limit();
		repeat (2) @(posedge S_AXI_ACLK);
		// Both valids low while reset is held
		@(negedge S_AXI_ACLK);
		check_bit("read address valid in reset", 1'b0, ar.valid);
		check_bit("instruction valid in reset", 1'b0, insn.valid);
		@(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;
		for (int i = 0; i < n_rows; i++)
			run_row(rows[i]);
		$display("Done: %0d checks, %0d instruction errors, %0d flag errors",
			checks, insn_errs, bit_errs);
		if (insn_errs == 0 && bit_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* sources.f */
logic/axil_rd_pkg.sv
logic/fetch_pkg.sv
logic/fetch_ctrl.sv
logic/fetch_addr_gen.sv
logic/beat_fifo.sv
logic/insn_unpack.sv
logic/axil_fetch_top.sv
test/axil_code_mem.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module fetch_tb -f sources.f -o fetch_sim > build.log 2>&1 &&
./obj_dir/fetch_sim > sim.log 2>&1 ||
{ echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
